// File: src/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	localparam int LCD_WORD_W = 10; // RS, RW and one byte
	localparam int LCD_DATA_W = 8;

	// One bus word, read either as a character write or as a set-address command
	typedef union packed {
		struct packed {
			logic                  rs;
			logic                  rw;
			logic [LCD_DATA_W-1:0] code;
		} chr;
		struct packed {
			logic                  rs;
			logic                  rw;
			logic                  set_addr; // DDRAM address instruction bit
			logic [LCD_DATA_W-2:0] addr;
		} cmd;
	} lcd_word_u;

	// Register select
	localparam logic RS_DATA = 1'b1;
	localparam logic RS_CMD  = 1'b0;

	// Start of each display line in DDRAM
	localparam logic [LCD_DATA_W-2:0] ADDR_LINE1 = 7'h00;
	localparam logic [LCD_DATA_W-2:0] ADDR_LINE2 = 7'h40;

	localparam logic [LCD_DATA_W-1:0] CH_SPACE  = 8'h20;
	localparam logic [LCD_DATA_W-1:0] CH_COLON  = 8'h3A;
	localparam logic [LCD_DATA_W-1:0] CH_DOT    = 8'h2E;
	localparam logic [LCD_DATA_W-1:0] CH_DEGREE = 8'hDF; // HD44780 ROM code
	localparam logic [LCD_DATA_W-1:0] CH_C      = 8'h43;
	localparam logic [LCD_DATA_W-1:0] CH_DIGIT0 = 8'h30; // ASCII '0'

endpackage

`default_nettype wire

// File: src/face_pkg.sv
`default_nettype none

package face_pkg;

	// Screen codes
	localparam int SCREEN_W = 2;
	localparam logic [SCREEN_W-1:0] SCR_INTRO_A = 2'd0;
	localparam logic [SCREEN_W-1:0] SCR_INTRO_B = 2'd1;
	localparam logic [SCREEN_W-1:0] SCR_CLOCK   = 2'd2; // Final screen, stays here

	// Frame slot layout
	localparam int FRAME_SLOTS = 34;
	localparam int SLOT_W      = 6;
	localparam logic [SLOT_W-1:0] SLOT_LINE1 = 6'd0;  // Cursor to line 1
	localparam logic [SLOT_W-1:0] SLOT_LINE2 = 6'd17; // Cursor to line 2
	localparam logic [SLOT_W-1:0] SLOT_TIME0 = 6'd18; // Hour tens
	localparam logic [SLOT_W-1:0] SLOT_TEMP0 = 6'd27; // Temperature hundreds

	// Data inputs of the clock face
	localparam int DIGIT_SEL_W = 3;
	localparam int TIME_W      = 24; // Six BCD digits, hour tens on top
	localparam int BCD_W       = 4;

	// Text lines, leftmost character in the top byte
	localparam int LINE_CHARS = 16;
	localparam int LINE_POS_W = $clog2(LINE_CHARS);
	localparam int TEXT_W     = LINE_CHARS * 8;

	localparam logic [TEXT_W-1:0] INTRO_A_LINE1 = "   Eletronica   ";
	localparam logic [TEXT_W-1:0] INTRO_A_LINE2 = "    Digital     ";
	localparam logic [TEXT_W-1:0] INTRO_B_LINE1 = "   Projeto 4    ";
	localparam logic [TEXT_W-1:0] INTRO_B_LINE2 = "    Verilog     ";

	// Clock face titles
	localparam logic [TEXT_W-1:0] TITLE_CLOCK  = "Relogio  Temp   ";
	localparam logic [TEXT_W-1:0] TITLE_ADJUST = "Ajuste Rel  Temp";
	localparam logic [TEXT_W-1:0] TITLE_ALARM  = "Ajuste A1   Temp";

	// Column of the alarm number in TITLE_ALARM, counted from 1 like the slots
	localparam int ALARM_DIGIT_COL = 9;

endpackage

`default_nettype wire

// File: src/screen_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module screen_sequencer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start_btn,
	output logic [face_pkg::SCREEN_W-1:0] screen,
	output logic                          intro_active
);
	import face_pkg::*;

	logic btn_q;
	logic btn_rise;

	assign btn_rise     = start_btn & ~btn_q; // Low on last sample, high now
	assign intro_active = (screen != SCR_CLOCK);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			btn_q  <= 1'b0;
			screen <= SCR_INTRO_A;
		end
		else
		begin
			btn_q <= start_btn;
			if (btn_rise)
			begin
				case (screen)
					SCR_INTRO_A: screen <= SCR_INTRO_B;
					default:     screen <= SCR_CLOCK; // Saturates at the clock face
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: src/face_composer.sv
`timescale 1ns/10ps
`default_nettype none

module face_composer (
	input  logic [face_pkg::SCREEN_W-1:0]    screen,
	input  logic [face_pkg::SLOT_W-1:0]      slot,
	input  logic                             blink,
	input  logic                             clock_mode,
	input  logic                             adjust_mode,
	input  logic                             alarm1_mode,
	input  logic                             alarm2_mode,
	input  logic                             alarm3_mode,
	input  logic [face_pkg::TIME_W-1:0]      time_bcd,
	input  logic                             temp_hundreds,
	input  logic [face_pkg::BCD_W-1:0]       temp_tens,
	input  logic [face_pkg::BCD_W-1:0]       temp_units,
	input  logic [face_pkg::BCD_W-1:0]       temp_tenths,
	input  logic [face_pkg::DIGIT_SEL_W-1:0] digit_sel,
	output lcd_pkg::lcd_word_u               next_word
);
	import lcd_pkg::*;
	import face_pkg::*;

	logic                  on_line2;
	logic [SLOT_W-1:0]     line_col;  // 1..16 inside a line
	logic [LINE_POS_W-1:0] char_pos;
	logic                  blank_on;
	logic [TEXT_W-1:0]     title_text;
	logic [LCD_DATA_W-1:0] face_char;
	logic [LCD_DATA_W-1:0] char_code;

	function automatic logic [LCD_DATA_W-1:0] digit_char(input logic [BCD_W-1:0] bcd);
		return CH_DIGIT0 + LCD_DATA_W'(bcd);
	endfunction

	function automatic logic [LCD_DATA_W-1:0] text_char(
		input logic [TEXT_W-1:0]     text,
		input logic [LINE_POS_W-1:0] pos
	);
		return text[(LINE_CHARS - 1 - pos) * LCD_DATA_W +: LCD_DATA_W];
	endfunction

	// Blanked when this digit is the one under adjustment
	function automatic logic [LCD_DATA_W-1:0] time_char(
		input logic [TIME_W-1:0]      t,
		input logic [DIGIT_SEL_W-1:0] idx,
		input logic                   blank,
		input logic [DIGIT_SEL_W-1:0] sel
	);
		if (blank && sel == idx)
			return CH_SPACE;
		return digit_char(t[idx * BCD_W +: BCD_W]);
	endfunction

	assign on_line2 = (slot > SLOT_LINE2);
	assign line_col = on_line2 ? slot - SLOT_LINE2 : slot;
	assign char_pos = line_col[LINE_POS_W-1:0] - 1'b1;
	assign blank_on = adjust_mode & blink;

	// Title priority: adjust, clock, then the alarms
	always_comb
	begin
		title_text = {LINE_CHARS{CH_SPACE}}; // No mode active
		if (adjust_mode)
			title_text = TITLE_ADJUST;
		else if (clock_mode)
			title_text = TITLE_CLOCK;
		else if (alarm1_mode | alarm2_mode | alarm3_mode)
		begin
			title_text = TITLE_ALARM;
			title_text[(LINE_CHARS - ALARM_DIGIT_COL) * LCD_DATA_W +: LCD_DATA_W] =
				alarm1_mode ? digit_char(4'd1) :
				alarm2_mode ? digit_char(4'd2) : digit_char(4'd3);
		end
	end

	// HH:MM:SS ddd.d°C
	always_comb
	begin
		case (slot)
			SLOT_TIME0:     face_char = time_char(time_bcd, 3'd5, blank_on, digit_sel);
			SLOT_TIME0 + 1: face_char = time_char(time_bcd, 3'd4, blank_on, digit_sel);
			SLOT_TIME0 + 2: face_char = CH_COLON;
			SLOT_TIME0 + 3: face_char = time_char(time_bcd, 3'd3, blank_on, digit_sel);
			SLOT_TIME0 + 4: face_char = time_char(time_bcd, 3'd2, blank_on, digit_sel);
			SLOT_TIME0 + 5: face_char = CH_COLON;
			SLOT_TIME0 + 6: face_char = time_char(time_bcd, 3'd1, blank_on, digit_sel);
			SLOT_TIME0 + 7: face_char = time_char(time_bcd, 3'd0, blank_on, digit_sel);
			SLOT_TEMP0:     face_char = digit_char(BCD_W'(temp_hundreds)); // '0' or '1'
			SLOT_TEMP0 + 1: face_char = digit_char(temp_tens);
			SLOT_TEMP0 + 2: face_char = digit_char(temp_units);
			SLOT_TEMP0 + 3: face_char = CH_DOT;
			SLOT_TEMP0 + 4: face_char = digit_char(temp_tenths);
			SLOT_TEMP0 + 5: face_char = CH_DEGREE;
			SLOT_TEMP0 + 6: face_char = CH_C;
			default:        face_char = CH_SPACE; // Gap before the temperature
		endcase
	end

	always_comb
	begin
		case (screen)
			SCR_INTRO_A:
				char_code = text_char(on_line2 ? INTRO_A_LINE2 : INTRO_A_LINE1, char_pos);
			SCR_INTRO_B:
				char_code = text_char(on_line2 ? INTRO_B_LINE2 : INTRO_B_LINE1, char_pos);
			default:
				char_code = on_line2 ? face_char : text_char(title_text, char_pos);
		endcase
	end

	always_comb
	begin
		next_word = '0;
		if (slot == SLOT_LINE1 || slot == SLOT_LINE2)
		begin
			next_word.cmd.rs       = RS_CMD;
			next_word.cmd.rw       = 1'b0; // Write
			next_word.cmd.set_addr = 1'b1;
			next_word.cmd.addr     = (slot == SLOT_LINE1) ? ADDR_LINE1 : ADDR_LINE2;
		end
		else
		begin
			next_word.chr.rs   = RS_DATA;
			next_word.chr.rw   = 1'b0;
			next_word.chr.code = char_code;
		end
	end

endmodule

`default_nettype wire

// File: src/lcd_write_pacer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_write_pacer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        lcd_busy,
	input  lcd_pkg::lcd_word_u          next_word,
	output logic [face_pkg::SLOT_W-1:0] slot,
	output logic                        lcd_en,
	output lcd_pkg::lcd_word_u          lcd_word
);
	import face_pkg::*;

	logic write_now;
	logic last_slot;

	// At least one idle cycle after every strobe
	assign write_now = !lcd_en && !lcd_busy;
	assign last_slot = (slot == SLOT_W'(FRAME_SLOTS - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			slot     <= '0;
			lcd_en   <= 1'b0;
			lcd_word <= '0;
		end
		else
		begin
			lcd_en <= write_now; // One-cycle strobe
			if (write_now)
			begin
				lcd_word <= next_word;
				slot     <= last_slot ? '0 : slot + 1'b1; // Frame repeats
			end
		end
	end

endmodule

`default_nettype wire

// File: src/lcd_face_top.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_face_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start_btn,
	input  logic                             blink,
	input  logic                             clock_mode,
	input  logic                             adjust_mode,
	input  logic                             alarm1_mode,
	input  logic                             alarm2_mode,
	input  logic                             alarm3_mode,
	input  logic [face_pkg::TIME_W-1:0]      time_bcd,
	input  logic                             temp_hundreds,
	input  logic [face_pkg::BCD_W-1:0]       temp_tens,
	input  logic [face_pkg::BCD_W-1:0]       temp_units,
	input  logic [face_pkg::BCD_W-1:0]       temp_tenths,
	input  logic [face_pkg::DIGIT_SEL_W-1:0] digit_sel,
	input  logic                             lcd_busy,
	output logic                             lcd_en,
	output logic [lcd_pkg::LCD_WORD_W-1:0]   lcd_word,
	output logic                             intro_active
);
	import lcd_pkg::*;
	import face_pkg::*;

	logic [SCREEN_W-1:0] screen;
	logic [SLOT_W-1:0]   slot;
	lcd_word_u           next_word; // Word for the slot about to be written

	screen_sequencer u_screen_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_btn    (start_btn),
		.screen       (screen),
		.intro_active (intro_active)
	);

	face_composer u_face_composer (
		.screen        (screen),
		.slot          (slot),
		.blink         (blink),
		.clock_mode    (clock_mode),
		.adjust_mode   (adjust_mode),
		.alarm1_mode   (alarm1_mode),
		.alarm2_mode   (alarm2_mode),
		.alarm3_mode   (alarm3_mode),
		.time_bcd      (time_bcd),
		.temp_hundreds (temp_hundreds),
		.temp_tens     (temp_tens),
		.temp_units    (temp_units),
		.temp_tenths   (temp_tenths),
		.digit_sel     (digit_sel),
		.next_word     (next_word)
	);

	lcd_write_pacer u_lcd_write_pacer (
		.clk       (clk),
		.rst_n     (rst_n),
		.lcd_busy  (lcd_busy),
		.next_word (next_word),
		.slot      (slot),
		.lcd_en    (lcd_en),
		.lcd_word  (lcd_word)
	);

endmodule

`default_nettype wire

// File: test/lcd_face_checker.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_face_checker (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           lcd_busy,
	input logic                           lcd_en,
	input logic [lcd_pkg::LCD_WORD_W-1:0] lcd_word,
	input logic                           intro_active
);
	int unsigned fail_count = 0; // Failed assertions so far

	// Reset values show on the edge after reset is sampled
	reset_state: assert property (@(posedge clk)
		!rst_n |=> (!lcd_en && intro_active && lcd_word == '0))
	else
	begin
		fail_count++;
		$error("Outputs not at their reset values after reset");
	end

	single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_en |=> !lcd_en)
	else
	begin
		fail_count++;
		$error("lcd_en high on two consecutive cycles");
	end

	strobe_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_en |-> !$past(lcd_busy))
	else
	begin
		fail_count++;
		$error("lcd_en raised while lcd_busy was high");
	end

	// Clock face is final
	intro_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		!intro_active |=> !intro_active)
	else
	begin
		fail_count++;
		$error("intro_active went high again after the clock face");
	end

endmodule

bind lcd_face_top lcd_face_checker u_lcd_face_checker (
	.clk          (clk),
	.rst_n        (rst_n),
	.lcd_busy     (lcd_busy),
	.lcd_en       (lcd_en),
	.lcd_word     (lcd_word),
	.intro_active (intro_active)
);

`default_nettype wire

// File: test/lcd_face_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_face_tb;
	import lcd_pkg::*;
	import face_pkg::*;

	localparam int CLK_HALF    = 20; // 40 ns period
	localparam int NUM_FRAMES  = 15;
	localparam int CYCLE_LIMIT = 16 * FRAME_SLOTS * 8 + 200;

	localparam logic [127:0] TEXT_A_TOP = "   Eletronica   ";
	localparam logic [127:0] TEXT_A_BOT = "    Digital     ";
	localparam logic [127:0] TEXT_B_TOP = "   Projeto 4    ";
	localparam logic [127:0] TEXT_B_BOT = "    Verilog     ";

	logic                   clk;
	logic                   rst_n;
	logic                   start_btn;
	logic                   blink;
	logic                   clock_mode;
	logic                   adjust_mode;
	logic                   alarm1_mode;
	logic                   alarm2_mode;
	logic                   alarm3_mode;
	logic [TIME_W-1:0]      time_bcd;
	logic                   temp_hundreds;
	logic [BCD_W-1:0]       temp_tens;
	logic [BCD_W-1:0]       temp_units;
	logic [BCD_W-1:0]       temp_tenths;
	logic [DIGIT_SEL_W-1:0] digit_sel;
	logic                   lcd_busy;
	logic                   lcd_en;
	lcd_word_u              lcd_word;
	logic                   intro_active;

	logic [31:0]         lfsr_state;
	logic [SCREEN_W-1:0] exp_screen; // Screen the DUT should show
	int                  slot_count;
	int                  frame_count;
	int                  cycle_count;
	int                  error_count;
	int                  check_count;

	lcd_face_top u_lcd_face_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_btn     (start_btn),
		.blink         (blink),
		.clock_mode    (clock_mode),
		.adjust_mode   (adjust_mode),
		.alarm1_mode   (alarm1_mode),
		.alarm2_mode   (alarm2_mode),
		.alarm3_mode   (alarm3_mode),
		.time_bcd      (time_bcd),
		.temp_hundreds (temp_hundreds),
		.temp_tens     (temp_tens),
		.temp_units    (temp_units),
		.temp_tenths   (temp_tenths),
		.digit_sel     (digit_sel),
		.lcd_busy      (lcd_busy),
		.lcd_en        (lcd_en),
		.lcd_word      (lcd_word),
		.intro_active  (intro_active)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [3:0] random_digit(input int limit);
		return 4'(random_bits(4) % limit);
	endfunction

	function automatic logic [7:0] time_digit(input int idx);
		if (adjust_mode && blink && int'(digit_sel) == idx)
			return 8'h20; // Digit under adjustment blanks
		return 8'h30 + 8'(time_bcd[idx * 4 +: 4]);
	endfunction

	// HH:MM:SS ddd.d°C
	function automatic logic [7:0] line2_char(input int col);
		case (col)
			0:       return time_digit(5);
			1:       return time_digit(4);
			2, 5:    return 8'h3A;
			3:       return time_digit(3);
			4:       return time_digit(2);
			6:       return time_digit(1);
			7:       return time_digit(0);
			8:       return 8'h20;
			9:       return 8'h30 + 8'(temp_hundreds);
			10:      return 8'h30 + 8'(temp_tens);
			11:      return 8'h30 + 8'(temp_units);
			12:      return 8'h2E;
			13:      return 8'h30 + 8'(temp_tenths);
			14:      return 8'hDF;
			default: return 8'h43;
		endcase
	endfunction

	function automatic logic [7:0] title_char(input int col);
		logic [127:0] t;
		if (adjust_mode)
			t = "Ajuste Rel  Temp";
		else if (clock_mode)
			t = "Relogio  Temp   ";
		else if (alarm1_mode)
			t = "Ajuste A1   Temp";
		else if (alarm2_mode)
			t = "Ajuste A2   Temp";
		else if (alarm3_mode)
			t = "Ajuste A3   Temp";
		else
			t = {16{8'h20}};
		return t[(15 - col) * 8 +: 8];
	endfunction

	function automatic lcd_word_u expected_word(input int s);
		lcd_word_u    w;
		logic [127:0] text;
		int           col;
		w   = '0;
		col = (s > 17) ? s - 18 : s - 1;
		if (s == 0 || s == 17)
		begin
			w.cmd.rs       = RS_CMD;
			w.cmd.set_addr = 1'b1;
			w.cmd.addr     = (s == 0) ? 7'h00 : 7'h40;
			return w;
		end
		if (exp_screen == SCR_CLOCK)
			w.chr.code = (s > 17) ? line2_char(col) : title_char(col);
		else
		begin
			if (exp_screen == SCR_INTRO_A)
				text = (s > 17) ? TEXT_A_BOT : TEXT_A_TOP;
			else
				text = (s > 17) ? TEXT_B_BOT : TEXT_B_TOP;
			w.chr.code = text[(15 - col) * 8 +: 8];
		end
		w.chr.rs = RS_DATA;
		return w;
	endfunction

	task automatic check_pulse();
		lcd_word_u exp;
		exp = expected_word(slot_count);
		check_count++;
		assert (lcd_word == exp)
		else
		begin
			error_count++;
			$display("Mismatch at %0t: slot %0d expected %h, got %h",
				$time, slot_count, exp, lcd_word);
		end
		assert (intro_active == (exp_screen != SCR_CLOCK))
		else
		begin
			error_count++;
			$display("Mismatch at %0t: intro_active %b at slot %0d",
				$time, intro_active, slot_count);
		end
	endtask

	// Inputs for the frame about to start
	task automatic apply_phase(input int f);
		if (f <= 3)
		begin
			start_btn  <= 1'b1;
			exp_screen = (exp_screen == SCR_CLOCK) ? SCR_CLOCK : exp_screen + 1'b1;
		end
		clock_mode    <= (f == 2) || (f == 3);
		adjust_mode   <= (f == 3) || (f >= 9);
		alarm1_mode   <= (f == 2) || (f == 4); // Frame 2 puts the clock title over an alarm
		alarm2_mode   <= (f == 5) || (f == 8); // Frame 8 has two alarms set
		alarm3_mode   <= (f == 6) || (f == 8);
		blink         <= (f >= 9);
		digit_sel     <= (f >= 9) ? 3'(f - 9) : 3'd0;
		time_bcd      <= {random_digit(3), random_digit(10), random_digit(6),
			random_digit(10), random_digit(6), random_digit(10)};
		temp_hundreds <= 1'(random_bits(1));
		temp_tens     <= random_digit(10);
		temp_units    <= random_digit(10);
		temp_tenths   <= random_digit(10);
	endtask

	task automatic finish_run(input bit timed_out);
		int assert_fails;
		assert_fails = u_lcd_face_top.u_lcd_face_checker.fail_count;
		$display("Checks: %0d, mismatches: %0d, checker failures: %0d",
			check_count, error_count, assert_fails);
		if (!timed_out && error_count == 0 && assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	// Words are checked one edge after they are loaded
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		lcd_busy    <= (random_bits(2) == 32'd3); // Busy about one cycle in four
		if (rst_n && lcd_en)
		begin
			check_pulse();
			start_btn <= 1'b0;
			if (slot_count == FRAME_SLOTS - 1)
			begin
				slot_count  = 0;
				frame_count = frame_count + 1;
				apply_phase(frame_count);
			end
			else
				slot_count = slot_count + 1;
		end
	end

	initial
	begin
		lfsr_state    = 32'h067c63d3;
		rst_n         = 1'b0;
		start_btn     = 1'b0;
		blink         = 1'b0;
		clock_mode    = 1'b0;
		adjust_mode   = 1'b0;
		alarm1_mode   = 1'b0;
		alarm2_mode   = 1'b0;
		alarm3_mode   = 1'b0;
		time_bcd      = '0;
		temp_hundreds = 1'b0;
		temp_tens     = '0;
		temp_units    = '0;
		temp_tenths   = '0;
		digit_sel     = '0;
		lcd_busy      = 1'b0;
		exp_screen    = SCR_INTRO_A;
		slot_count    = 0;
		frame_count   = 0;
		cycle_count   = 0;
		error_count   = 0;
		check_count   = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		wait (frame_count == NUM_FRAMES);
		@(posedge clk);
		finish_run(1'b0);
	end

	initial
	begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout: %0d of %0d frames written after %0d cycles",
			frame_count, NUM_FRAMES, cycle_count);
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

// File: lcd_face.f
src/lcd_pkg.sv
src/face_pkg.sv
src/screen_sequencer.sv
src/face_composer.sv
src/lcd_write_pacer.sv
src/lcd_face_top.sv
test/lcd_face_checker.sv
test/lcd_face_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LCD face testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module lcd_face_tb -f lcd_face.f \
	--Mdir obj_dir -o lcd_face_sim

# Raised error limit lets the testbench print its closing lines
./obj_dir/lcd_face_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi
